//--- rtl/core_cfg_pkg.sv
// Machine size constants and function-unit encoding shared by the retirement backend
package core_cfg_pkg;

  // ============================================================
  // Datapath widths
  // ============================================================

  // Register data width
  localparam int unsigned XLEN = 32;

  // Program counter and memory address width
  localparam int unsigned PLEN = 32;

  // Architectural register index, 32 registers
  localparam int unsigned AREG_W = 5;

  // Exception cause code
  localparam int unsigned ECAUSE_W = 5;

  // ============================================================
  // Tag widths
  // ============================================================

  // ROB index field, covers depths up to 64
  localparam int unsigned ROB_IDX_W = 6;

  // Store buffer id field, covers depths up to 32
  localparam int unsigned SB_IDX_W = 5;

  // Unit that executes an instruction
  typedef enum logic [1:0] {
    FU_ALU    = 2'd0,
    FU_BRANCH = 2'd1,
    FU_LSU    = 2'd2
  } fu_e;

endpackage

//--- rtl/rob_pkg.sv
// Bundles passed between dispatch, reorder buffer, store buffer and register file
package rob_pkg;

  import core_cfg_pkg::*;

  // ============================================================
  // Front side
  // ============================================================

  // One instruction coming out of rename
  typedef struct packed {
    logic              valid;
    logic [PLEN-1:0]   pc;
    fu_e               fu;
    logic [AREG_W-1:0] areg;
    logic              has_rd;
    logic              is_store;
  } dispatch_slot_t;

  // Result of one execution unit
  typedef struct packed {
    logic                 valid;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      data;
    logic                 exception;
    logic [ECAUSE_W-1:0]  ecause;
    logic                 mispred;
    logic [PLEN-1:0]      redirect_pc;
  } wb_slot_t;

  // Address and data from the LSU for an allocated store
  typedef struct packed {
    logic                valid;
    logic [SB_IDX_W-1:0] sb_id;
    logic [PLEN-1:0]     addr;
    logic [XLEN-1:0]     data;
  } store_data_t;

  // ============================================================
  // Retire side
  // ============================================================

  // One retiring instruction
  typedef struct packed {
    logic                 valid;
    logic [PLEN-1:0]      pc;
    logic                 we;
    logic [AREG_W-1:0]    areg;
    logic [XLEN-1:0]      wdata;
    logic                 is_store;
    logic [SB_IDX_W-1:0]  sb_id;
    logic [ROB_IDX_W-1:0] rob_idx;
  } commit_slot_t;

  // Pipeline flush with restart pc
  // Cause is zero for a branch mispredict
  typedef struct packed {
    logic                valid;
    logic [PLEN-1:0]     pc;
    logic [ECAUSE_W-1:0] cause;
  } flush_t;

  // Store leaving the store buffer toward memory
  typedef struct packed {
    logic            valid;
    logic [PLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } mem_write_t;

endpackage

//--- rtl/rob.sv
// Reorder buffer with in-order commit, per-class commit limits, flush and operand query
`timescale 1ns/1ps

module rob
  import core_cfg_pkg::*, rob_pkg::*;
#(
  parameter int unsigned ROB_DEPTH      = 16,
  parameter int unsigned DISPATCH_WIDTH = 2,
  parameter int unsigned COMMIT_WIDTH   = 2,
  parameter int unsigned WB_WIDTH       = 2,
  parameter int unsigned QUERY_WIDTH    = 2
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  dispatch_slot_t [DISPATCH_WIDTH-1:0]          dispatch_i,
  input  logic [DISPATCH_WIDTH-1:0][SB_IDX_W-1:0]      dispatch_sb_id_i,
  input  logic                                         sb_room_i,
  output logic                                         dispatch_ready_o,
  output logic [DISPATCH_WIDTH-1:0][ROB_IDX_W-1:0]     dispatch_idx_o,
  input  wb_slot_t [WB_WIDTH-1:0]                      wb_i,
  output commit_slot_t [COMMIT_WIDTH-1:0]              commit_o,
  output flush_t                                       flush_o,
  input  logic [QUERY_WIDTH-1:0][ROB_IDX_W-1:0]        query_idx_i,
  output logic [QUERY_WIDTH-1:0]                       query_ready_o,
  output logic [QUERY_WIDTH-1:0][XLEN-1:0]             query_data_o,
  output logic                                         empty_o
);

  localparam int unsigned PTR_W = $clog2(ROB_DEPTH);
  localparam int unsigned CNT_W = $clog2(ROB_DEPTH + 1);

  // Per-cycle retire limits
  localparam int unsigned MAX_BR = 1;
  localparam int unsigned MAX_ST = 1;
  localparam int unsigned MAX_LD = 2;

  typedef struct packed {
    logic                complete;
    logic                exception;
    logic [ECAUSE_W-1:0] ecause;
    logic                mispred;
    logic [PLEN-1:0]     redirect_pc;
    fu_e                 fu;
    logic [AREG_W-1:0]   areg;
    logic                has_rd;
    logic                is_store;
    logic [SB_IDX_W-1:0] sb_id;
    logic [PLEN-1:0]     pc;
    logic [XLEN-1:0]     data;
  } rob_entry_t;

  rob_entry_t ram_q [ROB_DEPTH];

  logic [PTR_W-1:0] head_q, tail_q;
  logic [CNT_W-1:0] count_q;
  logic [$clog2(DISPATCH_WIDTH+1)-1:0] n_disp;
  logic [$clog2(COMMIT_WIDTH+1)-1:0]   n_commit;

  // ============================================================
  // Dispatch
  // ============================================================

  // A group arriving with a flush is younger than the flushing instruction
  assign dispatch_ready_o = (count_q <= CNT_W'(ROB_DEPTH - DISPATCH_WIDTH))
                            && sb_room_i && !flush_o.valid;
  assign empty_o = (count_q == '0);

  // Groups are packed from slot 0, so valid slots sit at tail + position
  always_comb begin
    logic [PTR_W-1:0] slot;
    n_disp = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      slot              = tail_q + PTR_W'(i);
      dispatch_idx_o[i] = ROB_IDX_W'(slot);
      if (dispatch_ready_o && dispatch_i[i].valid) begin
        n_disp = n_disp + 1'b1;
      end
    end
  end

  // ============================================================
  // Commit and flush
  // ============================================================
  always_comb begin
    logic [PTR_W-1:0] idx;
    rob_entry_t       ent;
    logic             is_br, is_st, is_ld, fits, stop;
    int unsigned      n_br, n_st, n_ld;

    idx      = head_q;
    ent      = ram_q[head_q];
    stop     = 1'b0;
    n_br     = 0;
    n_st     = 0;
    n_ld     = 0;
    n_commit = '0;
    commit_o = '0;
    flush_o  = '0;

    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      idx   = head_q + PTR_W'(i);
      ent   = ram_q[idx];
      is_br = (ent.fu == FU_BRANCH);
      is_st = ent.is_store;
      is_ld = (ent.fu == FU_LSU) && !ent.is_store;
      fits  = !(is_br && n_br >= MAX_BR) && !(is_st && n_st >= MAX_ST)
              && !(is_ld && n_ld >= MAX_LD);

      if (!stop && (int'(count_q) > i) && ent.complete && fits) begin
        if (ent.exception) begin
          // Precise trap so nothing from here on retires
          stop          = 1'b1;
          flush_o.valid = 1'b1;
          flush_o.pc    = ent.pc;
          flush_o.cause = ent.ecause;
        end else begin
          commit_o[i].valid    = 1'b1;
          commit_o[i].pc       = ent.pc;
          commit_o[i].we       = ent.has_rd && (ent.areg != '0);
          commit_o[i].areg     = ent.areg;
          commit_o[i].wdata    = ent.data;
          commit_o[i].is_store = ent.is_store;
          commit_o[i].sb_id    = ent.sb_id;
          commit_o[i].rob_idx  = ROB_IDX_W'(idx);
          n_commit = n_commit + 1'b1;
          n_br     = n_br + (is_br ? 1 : 0);
          n_st     = n_st + (is_st ? 1 : 0);
          n_ld     = n_ld + (is_ld ? 1 : 0);
          // Mispredict retires itself, then redirects
          if (ent.mispred) begin
            stop          = 1'b1;
            flush_o.valid = 1'b1;
            flush_o.pc    = ent.redirect_pc;
            flush_o.cause = '0;
          end
        end
      end else begin
        stop = 1'b1;
      end
    end
  end

  // ============================================================
  // Pointers and entry storage
  // ============================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_o.valid) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + PTR_W'(n_commit);
      tail_q  <= tail_q + PTR_W'(n_disp);
      count_q <= count_q + CNT_W'(n_disp) - CNT_W'(n_commit);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (dispatch_ready_o && dispatch_i[i].valid) begin
        ram_q[tail_q + PTR_W'(i)] <= '{
          complete:    1'b0,
          exception:   1'b0,
          ecause:      '0,
          mispred:     1'b0,
          redirect_pc: '0,
          fu:          dispatch_i[i].fu,
          areg:        dispatch_i[i].areg,
          has_rd:      dispatch_i[i].has_rd,
          is_store:    dispatch_i[i].is_store,
          sb_id:       dispatch_sb_id_i[i],
          pc:          dispatch_i[i].pc,
          data:        '0
        };
      end
    end
    // Results for squashed entries are dropped
    for (int k = 0; k < WB_WIDTH; k++) begin
      if (wb_i[k].valid && !flush_o.valid) begin
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].complete    <= 1'b1;
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].data        <= wb_i[k].data;
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].exception   <= wb_i[k].exception;
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].ecause      <= wb_i[k].ecause;
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].mispred     <= wb_i[k].mispred;
        ram_q[wb_i[k].rob_idx[PTR_W-1:0]].redirect_pc <= wb_i[k].redirect_pc;
      end
    end
  end

  // Operand query over completed but not yet retired results
  always_comb begin
    for (int q = 0; q < QUERY_WIDTH; q++) begin
      query_ready_o[q] = ram_q[query_idx_i[q][PTR_W-1:0]].complete;
      query_data_o[q]  = ram_q[query_idx_i[q][PTR_W-1:0]].data;
    end
  end

endmodule

//--- rtl/store_buffer.sv
// In-order store queue, allocated at dispatch, released at commit, drained to memory
`timescale 1ns/1ps

module store_buffer
  import core_cfg_pkg::*, rob_pkg::*;
#(
  parameter int unsigned SB_DEPTH       = 8,
  parameter int unsigned DISPATCH_WIDTH = 2,
  parameter int unsigned COMMIT_WIDTH   = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  dispatch_slot_t [DISPATCH_WIDTH-1:0]     alloc_i,
  input  logic                                    alloc_en_i,
  output logic [DISPATCH_WIDTH-1:0][SB_IDX_W-1:0] alloc_id_o,
  output logic                                    room_o,
  input  store_data_t                             store_data_i,
  input  commit_slot_t [COMMIT_WIDTH-1:0]         commit_i,
  input  flush_t                                  flush_i,
  output mem_write_t                              mem_write_o
);

  localparam int unsigned IDX_W = $clog2(SB_DEPTH);
  // Extra wrap bit tells full from empty
  localparam int unsigned PTR_W = IDX_W + 1;

  // head .. cmt is committed, cmt .. tail is still speculative
  logic [PTR_W-1:0] head_q, cmt_q, tail_q;
  logic [PTR_W-1:0] cmt_d;
  logic [PTR_W-1:0] used;
  logic [$clog2(DISPATCH_WIDTH+1)-1:0] n_alloc;
  logic [$clog2(COMMIT_WIDTH+1)-1:0]   n_cmt;
  logic                                drain;

  logic [SB_DEPTH-1:0] has_data_q;
  logic [PLEN-1:0]     addr_q [SB_DEPTH];
  logic [XLEN-1:0]     data_q [SB_DEPTH];

  assign used   = tail_q - head_q;
  assign room_o = (used <= PTR_W'(SB_DEPTH - DISPATCH_WIDTH));

  // Each store slot gets tail plus the stores ahead of it in the group
  always_comb begin
    logic [PTR_W-1:0] slot_ptr;
    slot_ptr = tail_q;
    n_alloc  = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      alloc_id_o[i] = SB_IDX_W'(slot_ptr[IDX_W-1:0]);
      if (alloc_i[i].valid && alloc_i[i].is_store) begin
        slot_ptr = slot_ptr + 1'b1;
        n_alloc  = n_alloc + 1'b1;
      end
    end
  end

  // Stores retire in allocation order
  always_comb begin
    n_cmt = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (commit_i[i].valid && commit_i[i].is_store) begin
        n_cmt = n_cmt + 1'b1;
      end
    end
    cmt_d = cmt_q + PTR_W'(n_cmt);
  end

  // ============================================================
  // Drain, oldest committed store with data
  // ============================================================
  assign drain             = (head_q != cmt_q) && has_data_q[head_q[IDX_W-1:0]];
  assign mem_write_o.valid = drain;
  assign mem_write_o.addr  = addr_q[head_q[IDX_W-1:0]];
  assign mem_write_o.data  = data_q[head_q[IDX_W-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      cmt_q  <= '0;
      tail_q <= '0;
    end else begin
      cmt_q <= cmt_d;
      if (drain) begin
        head_q <= head_q + 1'b1;
      end
      // Flush keeps stores committed in the same cycle
      if (flush_i.valid) begin
        tail_q <= cmt_d;
      end else if (alloc_en_i) begin
        tail_q <= tail_q + PTR_W'(n_alloc);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      has_data_q <= '0;
    end else begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        if (alloc_en_i && alloc_i[i].valid && alloc_i[i].is_store) begin
          has_data_q[alloc_id_o[i][IDX_W-1:0]] <= 1'b0;
        end
      end
      if (store_data_i.valid) begin
        has_data_q[store_data_i.sb_id[IDX_W-1:0]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_data_i.valid) begin
      addr_q[store_data_i.sb_id[IDX_W-1:0]] <= store_data_i.addr;
      data_q[store_data_i.sb_id[IDX_W-1:0]] <= store_data_i.data;
    end
  end

endmodule

//--- rtl/arch_regfile.sv
// Architectural register file updated by retiring instructions, one read port
`timescale 1ns/1ps

module arch_regfile
  import core_cfg_pkg::*, rob_pkg::*;
#(
  parameter int unsigned COMMIT_WIDTH = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  commit_slot_t [COMMIT_WIDTH-1:0] commit_i,
  input  logic [AREG_W-1:0]               raddr_i,
  output logic [XLEN-1:0]                 rdata_o
);

  localparam int unsigned NREGS = 2 ** AREG_W;

  logic [XLEN-1:0] regs_q [NREGS];

  // Later slot is younger, so its write lands last
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NREGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (commit_i[i].valid && commit_i[i].we && (commit_i[i].areg != '0)) begin
          regs_q[commit_i[i].areg] <= commit_i[i].wdata;
        end
      end
    end
  end

  // x0 is never written and stays zero
  assign rdata_o = regs_q[raddr_i];

endmodule

//--- rtl/backend_top.sv
// Retirement subsystem joining the reorder buffer, store buffer and register file
`timescale 1ns/1ps

module backend_top
  import core_cfg_pkg::*, rob_pkg::*;
#(
  parameter int unsigned ROB_DEPTH      = 16,
  parameter int unsigned DISPATCH_WIDTH = 2,
  parameter int unsigned COMMIT_WIDTH   = 2,
  parameter int unsigned WB_WIDTH       = 2,
  parameter int unsigned QUERY_WIDTH    = 2,
  parameter int unsigned SB_DEPTH       = 8
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  dispatch_slot_t [DISPATCH_WIDTH-1:0]      dispatch_i,
  output logic                                     dispatch_ready_o,
  output logic [DISPATCH_WIDTH-1:0][ROB_IDX_W-1:0] dispatch_idx_o,
  output logic [DISPATCH_WIDTH-1:0][SB_IDX_W-1:0]  dispatch_sb_id_o,
  input  wb_slot_t [WB_WIDTH-1:0]                  wb_i,
  input  store_data_t                              store_data_i,
  input  logic [QUERY_WIDTH-1:0][ROB_IDX_W-1:0]    query_idx_i,
  output logic [QUERY_WIDTH-1:0]                   query_ready_o,
  output logic [QUERY_WIDTH-1:0][XLEN-1:0]         query_data_o,
  output commit_slot_t [COMMIT_WIDTH-1:0]          commit_o,
  output flush_t                                   flush_o,
  output mem_write_t                               mem_write_o,
  input  logic [AREG_W-1:0]                        reg_raddr_i,
  output logic [XLEN-1:0]                          reg_rdata_o
);

  // Store buffer space for a full group
  logic sb_room;

  rob #(
    .ROB_DEPTH      (ROB_DEPTH),
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .COMMIT_WIDTH   (COMMIT_WIDTH),
    .WB_WIDTH       (WB_WIDTH),
    .QUERY_WIDTH    (QUERY_WIDTH)
  ) u_rob (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dispatch_i       (dispatch_i),
    .dispatch_sb_id_i (dispatch_sb_id_o),
    .sb_room_i        (sb_room),
    .dispatch_ready_o (dispatch_ready_o),
    .dispatch_idx_o   (dispatch_idx_o),
    .wb_i             (wb_i),
    .commit_o         (commit_o),
    .flush_o          (flush_o),
    .query_idx_i      (query_idx_i),
    .query_ready_o    (query_ready_o),
    .query_data_o     (query_data_o),
    .empty_o          ()
  );

  store_buffer #(
    .SB_DEPTH       (SB_DEPTH),
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .COMMIT_WIDTH   (COMMIT_WIDTH)
  ) u_store_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (dispatch_i),
    .alloc_en_i   (dispatch_ready_o),
    .alloc_id_o   (dispatch_sb_id_o),
    .room_o       (sb_room),
    .store_data_i (store_data_i),
    .commit_i     (commit_o),
    .flush_i      (flush_o),
    .mem_write_o  (mem_write_o)
  );

  arch_regfile #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_arch_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .commit_i (commit_o),
    .raddr_i  (reg_raddr_i),
    .rdata_o  (reg_rdata_o)
  );

endmodule

//--- sim/tb_vectors.svh
// Stimulus and expected retirement records for the backend testbench
// Columns are op, a, b, c, d, e
//   DISP  a=pc of slot 0, b/c=slot codes {valid[8], store[7], fu[6:5], areg[4:0]}
//   WB    a=rob index, b=data, c={mispred[8], exception[7], cause[4:0]}, d=redirect pc
//   SD    a=sb id, b=address, c=data
//   EXPC  a=pc, b=we, c=areg, d=wdata, e=is_store
//   EXPF  a=pc, b=cause        EXPM  a=address, b=data
//   QRY   a=rob index, b=ready, c=data       REG  a=areg, b=value
localparam int NROWS = 63;

row_t vec [NROWS] = '{
  // Out-of-order writeback, operand query, x0 stays zero
  '{OP_DISP,  'h100,      'h105,      'h106,      'h0,   'h0},
  '{OP_DISP,  'h108,      'h100,      'h147,      'h0,   'h0},
  '{OP_EXPC,  'h100,      'h1,        'h5,        'h11111111, 'h0},
  '{OP_EXPC,  'h104,      'h1,        'h6,        'h22222222, 'h0},
  '{OP_EXPC,  'h108,      'h0,        'h0,        'h33333333, 'h0},
  '{OP_EXPC,  'h10c,      'h1,        'h7,        'h44444444, 'h0},
  '{OP_WB,    'h1,        'h22222222, 'h0,        'h0,   'h0},
  '{OP_QRY,   'h1,        'h1,        'h22222222, 'h0,   'h0},
  '{OP_QRY,   'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_WB,    'h0,        'h11111111, 'h0,        'h0,   'h0},
  '{OP_WB,    'h2,        'h33333333, 'h0,        'h0,   'h0},
  '{OP_WB,    'h3,        'h44444444, 'h0,        'h0,   'h0},
  '{OP_DRAIN, 'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'h5,        'h11111111, 'h0,        'h0,   'h0},
  '{OP_REG,   'h7,        'h44444444, 'h0,        'h0,   'h0},
  '{OP_REG,   'h0,        'h0,        'h0,        'h0,   'h0},
  // Two branches, then two stores, one of each per cycle
  '{OP_DISP,  'h200,      'h120,      'h128,      'h0,   'h0},
  '{OP_EXPC,  'h200,      'h0,        'h0,        'h0,   'h0},
  '{OP_EXPC,  'h204,      'h1,        'h8,        'h55,  'h0},
  '{OP_WB,    'h4,        'h0,        'h0,        'h0,   'h0},
  '{OP_WB,    'h5,        'h55,       'h0,        'h0,   'h0},
  '{OP_DISP,  'h208,      'h1c0,      'h1c0,      'h0,   'h0},
  '{OP_EXPC,  'h208,      'h0,        'h0,        'h0,   'h1},
  '{OP_EXPC,  'h20c,      'h0,        'h0,        'h0,   'h1},
  '{OP_EXPM,  'h1000,     'ha0,       'h0,        'h0,   'h0},
  '{OP_EXPM,  'h1004,     'ha1,       'h0,        'h0,   'h0},
  '{OP_SD,    'h0,        'h1000,     'ha0,       'h0,   'h0},
  '{OP_SD,    'h1,        'h1004,     'ha1,       'h0,   'h0},
  '{OP_WB,    'h6,        'h0,        'h0,        'h0,   'h0},
  '{OP_WB,    'h7,        'h0,        'h0,        'h0,   'h0},
  '{OP_DRAIN, 'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'h8,        'h55,       'h0,        'h0,   'h0},
  // Exception behind a store
  '{OP_DISP,  'h300,      'h1c0,      'h109,      'h0,   'h0},
  '{OP_DISP,  'h308,      'h14a,      'h10b,      'h0,   'h0},
  '{OP_EXPC,  'h300,      'h0,        'h0,        'h0,   'h1},
  '{OP_EXPF,  'h304,      'h5,        'h0,        'h0,   'h0},
  '{OP_EXPM,  'h2000,     'hb0,       'h0,        'h0,   'h0},
  '{OP_SD,    'h2,        'h2000,     'hb0,       'h0,   'h0},
  '{OP_WB,    'h8,        'h0,        'h0,        'h0,   'h0},
  '{OP_WB,    'h9,        'h0,        'h85,       'h0,   'h0},
  '{OP_WB,    'ha,        'h77,       'h0,        'h0,   'h0},
  '{OP_WB,    'hb,        'h88,       'h0,        'h0,   'h0},
  '{OP_DRAIN, 'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'h9,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'hb,        'h0,        'h0,        'h0,   'h0},
  // Mispredict with a younger store that must never drain
  '{OP_DISP,  'h400,      'h12c,      'h1c0,      'h0,   'h0},
  '{OP_EXPC,  'h400,      'h1,        'hc,        'h404, 'h0},
  '{OP_EXPF,  'h500,      'h0,        'h0,        'h0,   'h0},
  '{OP_SD,    'h3,        'h3000,     'hdead,     'h0,   'h0},
  '{OP_WB,    'h0,        'h404,      'h100,      'h500, 'h0},
  '{OP_WB,    'h1,        'h0,        'h0,        'h0,   'h0},
  '{OP_DRAIN, 'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'hc,        'h404,      'h0,        'h0,   'h0},
  // Restart after flush reuses the freed store id
  '{OP_DISP,  'h600,      'h1c0,      'h10d,      'h0,   'h0},
  '{OP_EXPC,  'h600,      'h0,        'h0,        'h0,   'h1},
  '{OP_EXPC,  'h604,      'h1,        'hd,        'h99,  'h0},
  '{OP_EXPM,  'h4000,     'hc3,       'h0,        'h0,   'h0},
  '{OP_SD,    'h3,        'h4000,     'hc3,       'h0,   'h0},
  '{OP_WB,    'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_WB,    'h1,        'h99,       'h0,        'h0,   'h0},
  '{OP_DRAIN, 'h0,        'h0,        'h0,        'h0,   'h0},
  '{OP_REG,   'hd,        'h99,       'h0,        'h0,   'h0},
  '{OP_REG,   'h5,        'h11111111, 'h0,        'h0,   'h0}
};

//--- sim/tb_backend.sv
// Table-driven testbench for the retirement backend with scoreboard and watchdog
`timescale 1ns/1ps

module tb_backend
  import core_cfg_pkg::*, rob_pkg::*;
;

  localparam logic [3:0] OP_DISP  = 4'd0;
  localparam logic [3:0] OP_WB    = 4'd1;
  localparam logic [3:0] OP_SD    = 4'd2;
  localparam logic [3:0] OP_EXPC  = 4'd3;
  localparam logic [3:0] OP_EXPF  = 4'd4;
  localparam logic [3:0] OP_EXPM  = 4'd5;
  localparam logic [3:0] OP_QRY   = 4'd6;
  localparam logic [3:0] OP_REG   = 4'd7;
  localparam logic [3:0] OP_DRAIN = 4'd8;

  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] a, b, c, d, e;
  } row_t;

  `include "tb_vectors.svh"

  logic clk_i;
  logic rst_ni;
  dispatch_slot_t [1:0]              dispatch_i;
  logic                              dispatch_ready_o;
  logic [1:0][ROB_IDX_W-1:0]         dispatch_idx_o;
  logic [1:0][SB_IDX_W-1:0]          dispatch_sb_id_o;
  wb_slot_t [1:0]                    wb_i;
  store_data_t                       store_data_i;
  logic [1:0][ROB_IDX_W-1:0]         query_idx_i;
  logic [1:0]                        query_ready_o;
  logic [1:0][XLEN-1:0]              query_data_o;
  commit_slot_t [1:0]                commit_o;
  flush_t                            flush_o;
  mem_write_t                        mem_write_o;
  logic [AREG_W-1:0]                 reg_raddr_i;
  logic [XLEN-1:0]                   reg_rdata_o;

  // Reference model state
  commit_slot_t exp_c [$];
  flush_t       exp_f [$];
  mem_write_t   exp_m [$];
  fu_e          fu_m [16];
  int           tail_m, head_m, sb_tail_m, sb_cmt_m;
  int           mismatch_cnt, other_cnt;
  logic [31:0]  lcg_state = 32'd29154;

  backend_top UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  task automatic report_mismatch(input string msg);
    mismatch_cnt++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    other_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // ============================================================
  // Stimulus tasks
  // ============================================================
  task automatic send_dispatch(input row_t r);
    dispatch_slot_t [1:0] d;
    logic [31:0] code [2];
    int nst;
    int nval;
    code[0] = r.b;
    code[1] = r.c;
    nst = 0;
    nval = 0;
    for (int i = 0; i < 2; i++) begin
      d[i].valid    = code[i][8];
      d[i].pc       = r.a + 32'(4 * i);
      d[i].fu       = fu_e'(code[i][6:5]);
      d[i].areg     = code[i][4:0];
      d[i].has_rd   = (code[i][4:0] != 0);
      d[i].is_store = code[i][7];
    end
    @(posedge clk_i);
    dispatch_i <= d;
    // Hold the group until the ROB takes it
    do @(negedge clk_i); while (!dispatch_ready_o);
    for (int i = 0; i < 2; i++) begin
      if (d[i].valid) begin
        assert (dispatch_idx_o[i] == ROB_IDX_W'((tail_m + i) % 16)
                && (!d[i].is_store || dispatch_sb_id_o[i] == SB_IDX_W'((sb_tail_m + nst) % 8)))
        else report_mismatch($sformatf("dispatch slot %0d got idx %0d sb %0d", i,
                                       dispatch_idx_o[i], dispatch_sb_id_o[i]));
        fu_m[(tail_m + i) % 16] = d[i].fu;
        nst += d[i].is_store ? 1 : 0;
        nval++;
      end
    end
    tail_m    = (tail_m + nval) % 16;
    sb_tail_m = sb_tail_m + nst;
    @(posedge clk_i);
    dispatch_i <= '0;
  endtask

  // Two results per cycle in the order given
  task automatic send_writebacks(input wb_slot_t q [$]);
    wb_slot_t [1:0] w;
    while (q.size() != 0) begin
      w = '0;
      w[0] = q.pop_front();
      if (q.size() != 0) begin
        w[1] = q.pop_front();
      end
      @(posedge clk_i);
      wb_i <= w;
    end
    @(posedge clk_i);
    wb_i <= '0;
  endtask

  // ============================================================
  // Scoreboard on the falling edge
  // ============================================================
  always @(negedge clk_i) begin
    int n_br;
    int n_st;
    commit_slot_t ec;
    flush_t ef;
    mem_write_t em;
    n_br = 0;
    n_st = 0;
    if (rst_ni) begin
      for (int i = 0; i < 2; i++) begin
        if (commit_o[i].valid) begin
          n_st += commit_o[i].is_store ? 1 : 0;
          n_br += (fu_m[head_m] == FU_BRANCH) ? 1 : 0;
          assert (commit_o[i].rob_idx == ROB_IDX_W'(head_m))
          else report_mismatch($sformatf("commit rob index %0d, expected %0d",
                                         commit_o[i].rob_idx, head_m));
          assert (exp_c.size() != 0)
          else report_failure($sformatf("unexpected commit of pc %h", commit_o[i].pc));
          if (exp_c.size() != 0) begin
            ec = exp_c.pop_front();
            assert (commit_o[i].pc == ec.pc && commit_o[i].we == ec.we
                    && commit_o[i].areg == ec.areg && commit_o[i].wdata == ec.wdata
                    && commit_o[i].is_store == ec.is_store)
            else report_mismatch($sformatf("commit pc %h data %h, expected pc %h data %h",
                                           commit_o[i].pc, commit_o[i].wdata, ec.pc, ec.wdata));
            if (ec.is_store) begin
              assert (commit_o[i].sb_id == SB_IDX_W'(sb_cmt_m % 8))
              else report_mismatch($sformatf("store commit sb id %0d, expected %0d",
                                             commit_o[i].sb_id, sb_cmt_m % 8));
            end
            sb_cmt_m += ec.is_store ? 1 : 0;
          end
          head_m = (head_m + 1) % 16;
        end
      end
      assert (n_br <= 1 && n_st <= 1)
      else report_failure("more than one branch or store retired in one cycle");
      if (flush_o.valid) begin
        assert (exp_f.size() != 0) else report_failure("unexpected flush");
        if (exp_f.size() != 0) begin
          ef = exp_f.pop_front();
          assert (flush_o.pc == ef.pc && flush_o.cause == ef.cause)
          else report_mismatch($sformatf("flush pc %h cause %0d, expected pc %h cause %0d",
                                         flush_o.pc, flush_o.cause, ef.pc, ef.cause));
        end
        tail_m    = 0;
        head_m    = 0;
        sb_tail_m = sb_cmt_m;
      end
      if (mem_write_o.valid) begin
        assert (exp_m.size() != 0)
        else report_failure($sformatf("unexpected store to %h", mem_write_o.addr));
        if (exp_m.size() != 0) begin
          em = exp_m.pop_front();
          assert (mem_write_o.addr == em.addr && mem_write_o.data == em.data)
          else report_mismatch($sformatf("store %h=%h, expected %h=%h", mem_write_o.addr,
                                         mem_write_o.data, em.addr, em.data));
        end
      end
    end
  end

  // Watchdog scaled by the table length
  initial begin
    #(NROWS * 40 * 20);
    $display("Timeout: the test table did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int i;
    int j;
    row_t r;
    wb_slot_t batch [$];
    wb_slot_t w;
    wb_slot_t tmp;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    dispatch_i = '0;
    wb_i = '0;
    store_data_i = '0;
    query_idx_i = '0;
    reg_raddr_i = '0;
    tail_m = 0;
    head_m = 0;
    sb_tail_m = 0;
    sb_cmt_m = 0;
    mismatch_cnt = 0;
    other_cnt = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (dispatch_ready_o) else report_failure("dispatch not ready after reset");
    i = 0;
    while (i < NROWS) begin
      r = vec[i];
      i++;
      case (r.op)
        OP_DISP: send_dispatch(r);
        OP_WB: begin
          batch.delete();
          w = '{valid: 1'b1, rob_idx: r.a[5:0], data: r.b, exception: r.c[7],
                ecause: r.c[4:0], mispred: r.c[8], redirect_pc: r.d};
          batch.push_back(w);
          while (i < NROWS && vec[i].op == OP_WB) begin
            r = vec[i];
            i++;
            w = '{valid: 1'b1, rob_idx: r.a[5:0], data: r.b, exception: r.c[7],
                  ecause: r.c[4:0], mispred: r.c[8], redirect_pc: r.d};
            batch.push_back(w);
          end
          // Shuffle the run of results
          for (int k = batch.size() - 1; k > 0; k--) begin
            j = lcg_next() % (k + 1);
            tmp = batch[k];
            batch[k] = batch[j];
            batch[j] = tmp;
          end
          send_writebacks(batch);
        end
        OP_SD: begin
          @(posedge clk_i);
          store_data_i <= '{valid: 1'b1, sb_id: r.a[4:0], addr: r.b, data: r.c};
          @(posedge clk_i);
          store_data_i <= '0;
        end
        OP_EXPC: exp_c.push_back(commit_slot_t'{valid: 1'b1, pc: r.a, we: r.b[0],
                                                areg: r.c[4:0], wdata: r.d,
                                                is_store: r.e[0], sb_id: '0, rob_idx: '0});
        OP_EXPF: exp_f.push_back(flush_t'{valid: 1'b1, pc: r.a, cause: r.b[4:0]});
        OP_EXPM: exp_m.push_back(mem_write_t'{valid: 1'b1, addr: r.a, data: r.b});
        OP_QRY: begin
          @(posedge clk_i);
          query_idx_i <= {2{r.a[5:0]}};
          @(negedge clk_i);
          for (int q = 0; q < 2; q++) begin
            assert (query_ready_o[q] == r.b[0] && (!r.b[0] || query_data_o[q] == r.c))
            else report_mismatch($sformatf("query %0d ready %0b data %h", r.a,
                                           query_ready_o[q], query_data_o[q]));
          end
        end
        OP_REG: begin
          @(posedge clk_i);
          reg_raddr_i <= r.a[4:0];
          @(negedge clk_i);
          assert (reg_rdata_o == r.b)
          else report_mismatch($sformatf("x%0d reads %h, expected %h", r.a, reg_rdata_o, r.b));
        end
        default: begin
          // Wait for every predicted event, then watch for stray ones
          while (exp_c.size() != 0 || exp_f.size() != 0 || exp_m.size() != 0) begin
            @(negedge clk_i);
          end
          repeat (3) @(negedge clk_i);
        end
      endcase
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/core_cfg_pkg.sv
rtl/rob_pkg.sv
rtl/rob.sv
rtl/store_buffer.sv
rtl/arch_regfile.sv
rtl/backend_top.sv
+incdir+sim
sim/tb_backend.sv

//--- Makefile
TOP = tb_backend

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
